/* hdl/mipsOp_macros.svh */
/*
 * Opcode, function and ALU codes for the integer execute subsystem.
 * Only the ALU and immediate groups are listed; memory, branch and
 * multiply encodings are not decoded.
 */
`ifndef MIPSOP_MACROS_SVH
`define MIPSOP_MACROS_SVH

// ====================
// Sizes
`define NUM_REGS   32
`define WORD_WIDTH 32

// ====================
// Opcodes
`define RTYPE 6'h00
`define ADDI  6'h08
`define ADDIU 6'h09
`define SLTI  6'h0a
`define SLTIU 6'h0b
`define ANDI  6'h0c
`define ORI   6'h0d
`define XORI  6'h0e
`define LUI   6'h0f

// ====================
// R-type function codes
`define SLL  6'h00
`define SRL  6'h02
`define SRA  6'h03
`define SLLV 6'h04
`define SRLV 6'h06
`define SRAV 6'h07
`define ADD  6'h20
`define ADDU 6'h21
`define SUB  6'h22
`define SUBU 6'h23
`define AND  6'h24
`define OR   6'h25
`define XOR  6'h26
`define NOR  6'h27
`define SLT  6'h2a
`define SLTU 6'h2b

// ALU functions
`define ALU_ADD  4'd0
`define ALU_SUB  4'd1
`define ALU_AND  4'd2
`define ALU_OR   4'd3
`define ALU_XOR  4'd4
`define ALU_NOR  4'd5
`define ALU_SLT  4'd6
`define ALU_SLTU 4'd7
`define ALU_SLL  4'd8
`define ALU_SRL  4'd9
`define ALU_SRA  4'd10

`endif

/* hdl/isaPkg.sv */
/*
 * Instruction format types.
 * Field widths follow the classic 32-bit MIPS encoding.
 */
`include "mipsOp_macros.svh"

package isaPkg;

    // Data or instruction word
    typedef logic [`WORD_WIDTH-1:0] wordT;

    typedef logic [4:0] regIdxT;   // Register index
    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;

    // Immediate and shift fields
    typedef logic [15:0] immT;
    typedef logic [4:0]  shamtT;

endpackage

/* hdl/ctrlPkg.sv */
/*
 * Decoded control types.
 * The destination select has two choices only, since no link-register
 * write exists without jumps.
 */
`include "mipsOp_macros.svh"

package ctrlPkg;

    // Holds one of the ALU_* codes
    typedef logic [3:0] aluFuncT;

    // Destination select
    typedef logic regDstT;

    localparam regDstT regDstRt = 1'b0;   // Immediate forms
    localparam regDstT regDstRd = 1'b1;   // R-type

endpackage

/* hdl/instrDecoder.sv */
/*
 * Decode stage. Registers control levels and operand fields on the
 * instrValid strobe. Unsupported instructions pass with decRegWrite low.
 * ADD, SUB and ADDI decode as their wrapping forms; no overflow trap.
 */
`timescale 1ns/1ps
`include "mipsOp_macros.svh"

module instrDecoder (
    input  logic             clk,
    input  logic             rstN,
    input  logic             instrValid,
    input  isaPkg::wordT     instr,
    output logic             decValid,
    output ctrlPkg::aluFuncT decAluFunc,
    output logic             decAluSrc,
    output logic             decUnsignedImm,
    output logic             decLuiShift,
    output logic             decVarShift,
    output logic             decRegWrite,
    output isaPkg::regIdxT   decDstReg,
    output isaPkg::regIdxT   decRs,
    output isaPkg::regIdxT   decRt,
    output isaPkg::immT      decImm,
    output isaPkg::shamtT    decShamt
);
    import isaPkg::*;
    import ctrlPkg::*;

    opcodeT  opcode;
    functT   funct;
    regIdxT  rdField;
    regIdxT  dstReg;
    regDstT  regDst;
    aluFuncT aluFunc;
    logic    aluSrc;
    logic    unsignedImm;
    logic    luiShift;
    logic    varShift;
    logic    regWrite;

    assign opcode  = instr[31:26];
    assign funct   = instr[5:0];
    assign rdField = instr[15:11];

    // ====================
    // Control decode
    always_comb
    begin
        regDst      = regDstRt;
        aluFunc     = `ALU_ADD;
        aluSrc      = 1'b0;
        unsignedImm = 1'b0;
        luiShift    = 1'b0;
        varShift    = 1'b0;
        regWrite    = 1'b0;

        case (opcode)
            `RTYPE:
            begin
                regDst   = regDstRd;
                regWrite = 1'b1;
                case (funct)
                    `ADD, `ADDU: aluFunc = `ALU_ADD;
                    `SUB, `SUBU: aluFunc = `ALU_SUB;
                    `AND:        aluFunc = `ALU_AND;
                    `OR:         aluFunc = `ALU_OR;
                    `XOR:        aluFunc = `ALU_XOR;
                    `NOR:        aluFunc = `ALU_NOR;
                    `SLT:        aluFunc = `ALU_SLT;
                    `SLTU:       aluFunc = `ALU_SLTU;
                    `SLL:        aluFunc = `ALU_SLL;
                    `SRL:        aluFunc = `ALU_SRL;
                    `SRA:        aluFunc = `ALU_SRA;
                    `SLLV, `SRLV, `SRAV:
                    begin
                        varShift = 1'b1;   // Amount from rs
                        aluFunc  = (funct == `SLLV) ? `ALU_SLL :
                                   (funct == `SRLV) ? `ALU_SRL : `ALU_SRA;
                    end
                    default: regWrite = 1'b0;   // MULT, JR and friends
                endcase
            end

            `ADDI, `ADDIU:
            begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end

            `SLTI, `SLTIU:
            begin
                aluFunc  = (opcode == `SLTI) ? `ALU_SLT : `ALU_SLTU;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end

            `ANDI, `ORI, `XORI:
            begin
                aluFunc     = (opcode == `ANDI) ? `ALU_AND :
                              (opcode == `ORI)  ? `ALU_OR  : `ALU_XOR;
                aluSrc      = 1'b1;
                unsignedImm = 1'b1;
                regWrite    = 1'b1;
            end

            `LUI:
            begin
                aluSrc   = 1'b1;
                luiShift = 1'b1;   // ADD with r0 yields imm << 16
                regWrite = 1'b1;
            end

            default:;
        endcase
    end

    assign dstReg = (regDst == regDstRd) ? rdField : instr[20:16];

    // ====================
    // Stage register
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            decValid    <= 1'b0;
            decRegWrite <= 1'b0;
        end
        else
        begin
            decValid    <= instrValid;
            decRegWrite <= instrValid & regWrite;
        end
    end

    always_ff @(posedge clk)
    begin
        if (instrValid)
        begin
            decAluFunc     <= aluFunc;
            decAluSrc      <= aluSrc;
            decUnsignedImm <= unsignedImm;
            decLuiShift    <= luiShift;
            decVarShift    <= varShift;
            decDstReg      <= dstReg;
            decRs          <= instr[25:21];
            decRt          <= instr[20:16];
            decImm         <= instr[15:0];
            decShamt       <= instr[10:6];
        end
    end

    // Accepted words must be fully known
    assert property (@(posedge clk) disable iff (!rstN) instrValid |-> !$isunknown(instr));

endmodule

/* hdl/regFile.sv */
/*
 * 32 x 32 register file. Two combinational reads, one write on clk.
 * Register zero always reads zero. Reset clears every entry.
 */
`timescale 1ns/1ps
`include "mipsOp_macros.svh"

module regFile (
    input  logic           clk,
    input  logic           rstN,
    input  logic           we,
    input  isaPkg::regIdxT waddr,
    input  isaPkg::wordT   wdata,
    input  isaPkg::regIdxT raddrA,
    input  isaPkg::regIdxT raddrB,
    output isaPkg::wordT   rdataA,
    output isaPkg::wordT   rdataB
);
    import isaPkg::*;

    wordT regs [`NUM_REGS];

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < `NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (we)
            regs[waddr] <= wdata;
    end

    assign rdataA = (raddrA == '0) ? '0 : regs[raddrA];
    assign rdataB = (raddrB == '0) ? '0 : regs[raddrB];

    // Write-back must already have filtered r0 targets
    assert property (@(posedge clk) disable iff (!rstN) we |-> (waddr != '0));

endmodule

/* hdl/aluExecute.sv */
/*
 * Execute stage. Operands come from the register file or, for the
 * instruction just ahead, from the result registers. Shift forms shift
 * rt by shamt or rs[4:0]. Result registered one edge after decode.
 */
`timescale 1ns/1ps
`include "mipsOp_macros.svh"

module aluExecute (
    input  logic             clk,
    input  logic             rstN,
    input  logic             decValid,
    input  ctrlPkg::aluFuncT decAluFunc,
    input  logic             decAluSrc,
    input  logic             decUnsignedImm,
    input  logic             decLuiShift,
    input  logic             decVarShift,
    input  logic             decRegWrite,
    input  isaPkg::regIdxT   decDstReg,
    input  isaPkg::regIdxT   decRs,
    input  isaPkg::regIdxT   decRt,
    input  isaPkg::immT      decImm,
    input  isaPkg::shamtT    decShamt,
    input  isaPkg::wordT     rdataA,
    input  isaPkg::wordT     rdataB,
    output isaPkg::regIdxT   exRs,
    output isaPkg::regIdxT   exRt,
    output logic             resValid,
    output logic             resWrite,
    output isaPkg::regIdxT   resDst,
    output isaPkg::wordT     resData
);
    import isaPkg::*;

    wordT  rsVal;
    wordT  rtVal;
    wordT  immExt;
    wordT  opB;
    wordT  aluResult;
    shamtT shiftAmt;

    assign exRs = decRs;
    assign exRt = decRt;

    // ====================
    // Operands
    assign rsVal = (resWrite && resDst != '0 && resDst == decRs) ? resData : rdataA;
    assign rtVal = (resWrite && resDst != '0 && resDst == decRt) ? resData : rdataB;

    assign immExt = decLuiShift    ? {decImm, 16'h0000} :
                    decUnsignedImm ? {16'h0000, decImm} :
                                     {{16{decImm[15]}}, decImm};

    assign opB      = decAluSrc ? immExt : rtVal;
    assign shiftAmt = decVarShift ? rsVal[4:0] : decShamt;

    always_comb
    begin
        case (decAluFunc)
            `ALU_ADD:  aluResult = rsVal + opB;
            `ALU_SUB:  aluResult = rsVal - opB;
            `ALU_AND:  aluResult = rsVal & opB;
            `ALU_OR:   aluResult = rsVal | opB;
            `ALU_XOR:  aluResult = rsVal ^ opB;
            `ALU_NOR:  aluResult = ~(rsVal | opB);
            `ALU_SLT:  aluResult = ($signed(rsVal) < $signed(opB)) ? wordT'(1) : '0;
            `ALU_SLTU: aluResult = (rsVal < opB) ? wordT'(1) : '0;
            `ALU_SLL:  aluResult = rtVal << shiftAmt;
            `ALU_SRL:  aluResult = rtVal >> shiftAmt;
            `ALU_SRA:  aluResult = wordT'($signed(rtVal) >>> shiftAmt);   // Sign fill
            default:   aluResult = '0;
        endcase
    end

    // ====================
    // Result register, also the bypass source
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            resValid <= 1'b0;
            resWrite <= 1'b0;
        end
        else
        begin
            resValid <= decValid;
            resWrite <= decRegWrite && (decDstReg != '0);   // r0 writes dropped here
        end
    end

    always_ff @(posedge clk)
    begin
        if (decValid)
        begin
            resDst  <= decDstReg;
            resData <= aluResult;
        end
    end

endmodule

/* hdl/writeBack.sv */
/*
 * Result stage. Commits writing results to the register file on the
 * next edge and shows each commit on the wb ports for one cycle.
 * Results that do not write are not reported.
 */
`timescale 1ns/1ps

module writeBack (
    input  logic           clk,
    input  logic           rstN,
    input  logic           resValid,
    input  logic           resWrite,
    input  isaPkg::regIdxT resDst,
    input  isaPkg::wordT   resData,
    output logic           rfWe,
    output isaPkg::regIdxT rfWaddr,
    output isaPkg::wordT   rfWdata,
    output logic           wbValid,
    output isaPkg::regIdxT wbReg,
    output isaPkg::wordT   wbData
);

    logic commit;

    assign commit = resValid & resWrite;

    // Register file port
    assign rfWe    = commit;
    assign rfWaddr = resDst;
    assign rfWdata = resData;

    // ====================
    // Outside report
    assign wbValid = commit;
    assign wbReg   = resDst;
    assign wbData  = resData;

    assert property (@(posedge clk) disable iff (!rstN) wbValid |-> (wbReg != '0));

endmodule

/* hdl/execCore.sv */
/*
 * Three-stage integer execute top. One instruction per cycle at most,
 * no back-pressure. wbValid follows the instrValid sample edge by
 * exactly one cycle.
 */
`timescale 1ns/1ps

module execCore (
    input  logic           clk,
    input  logic           rstN,
    input  logic           instrValid,
    input  isaPkg::wordT   instr,
    output logic           wbValid,
    output isaPkg::regIdxT wbReg,
    output isaPkg::wordT   wbData
);
    import isaPkg::*;
    import ctrlPkg::*;

    // Decode to execute
    logic    decValid;
    aluFuncT decAluFunc;
    logic    decAluSrc;
    logic    decUnsignedImm;
    logic    decLuiShift;
    logic    decVarShift;
    logic    decRegWrite;
    regIdxT  decDstReg;
    regIdxT  decRs;
    regIdxT  decRt;
    immT     decImm;
    shamtT   decShamt;

    // Register file ports
    regIdxT exRs;
    regIdxT exRt;
    wordT   rdataA;
    wordT   rdataB;
    logic   rfWe;
    regIdxT rfWaddr;
    wordT   rfWdata;

    // Result stage
    logic   resValid;
    logic   resWrite;
    regIdxT resDst;
    wordT   resData;

    instrDecoder decoder_i (
        .clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
        .decValid(decValid), .decAluFunc(decAluFunc), .decAluSrc(decAluSrc),
        .decUnsignedImm(decUnsignedImm), .decLuiShift(decLuiShift),
        .decVarShift(decVarShift), .decRegWrite(decRegWrite), .decDstReg(decDstReg),
        .decRs(decRs), .decRt(decRt), .decImm(decImm), .decShamt(decShamt)
    );

    aluExecute execute_i (
        .clk(clk), .rstN(rstN), .decValid(decValid), .decAluFunc(decAluFunc),
        .decAluSrc(decAluSrc), .decUnsignedImm(decUnsignedImm),
        .decLuiShift(decLuiShift), .decVarShift(decVarShift),
        .decRegWrite(decRegWrite), .decDstReg(decDstReg), .decRs(decRs),
        .decRt(decRt), .decImm(decImm), .decShamt(decShamt),
        .rdataA(rdataA), .rdataB(rdataB), .exRs(exRs), .exRt(exRt),
        .resValid(resValid), .resWrite(resWrite), .resDst(resDst), .resData(resData)
    );

    regFile regFile_i (
        .clk(clk), .rstN(rstN), .we(rfWe), .waddr(rfWaddr), .wdata(rfWdata),
        .raddrA(exRs), .raddrB(exRt), .rdataA(rdataA), .rdataB(rdataB)
    );

    writeBack writeBack_i (
        .clk(clk), .rstN(rstN), .resValid(resValid), .resWrite(resWrite),
        .resDst(resDst), .resData(resData), .rfWe(rfWe), .rfWaddr(rfWaddr),
        .rfWdata(rfWdata), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
    );

endmodule

/* test/execCoreTb.sv */
/*
 * Testbench for execCore. Vectors are read from test/execVectors.txt,
 * relative to the project root. A write-back is expected on the second
 * falling edge after an instruction is driven. Instructions that read the
 * previous destination go back-to-back so the bypass is used.
 */
`timescale 1ns/1ps
`include "mipsOp_macros.svh"

module execCoreTb;
    import isaPkg::*;

    typedef struct packed {
        logic        write;
        regIdxT      dst;
        wordT        data;
        int unsigned due;   // cycleCnt value at the checking edge
        int unsigned idx;
    } expectT;

    localparam int MaxVectors  = 64;
    localparam int ResetCycles = 10;

    logic   clk;
    logic   rstN;
    logic   instrValid;
    wordT   instr;
    logic   wbValid;
    regIdxT wbReg;
    wordT   wbData;

    // Vector table
    wordT   vecInstr [MaxVectors];
    logic   vecWrite [MaxVectors];
    regIdxT vecDst   [MaxVectors];
    wordT   vecData  [MaxVectors];
    int     numVectors = 0;
    bit     loaded = 1'b0;

    expectT      expQ [$];
    expectT      popped;
    bit          vecOk;
    int unsigned cycleCnt = 0;
    int          passCount = 0;
    int          failCount = 0;
    int          errors = 0;

    execCore dut_i (
        .clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
        cycleCnt <= cycleCnt + 1;

    // ====================
    // Vector file
    task automatic loadVectors();
        int               fd;
        int               code;
        logic [31:0]      fInstr;
        logic [31:0]      fWrite;
        logic [31:0]      fDst;
        logic [31:0]      fData;
        logic [8*256-1:0] skipLine;
        fd = $fopen("test/execVectors.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open test/execVectors.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && numVectors < MaxVectors)
        begin
            code = $fscanf(fd, " %h %h %h %h", fInstr, fWrite, fDst, fData);
            if (code == 4)
            begin
                vecInstr[numVectors] = fInstr;
                vecWrite[numVectors] = fWrite[0];
                vecDst[numVectors]   = fDst[4:0];
                vecData[numVectors]  = fData;
                numVectors++;
            end
            else
            begin
                if (code > 0)
                begin
                    $display("Malformed line in vector file after vector %0d", numVectors);
                    errors++;
                end
                // Comment or rest of line
                if ($fgets(skipLine, fd) == 0)
                    break;
            end
        end
        $fclose(fd);
    endtask

    // True when vector i reads the register that vector i-1 writes
    function automatic bit dependsOnPrevious(int i);
        wordT   cur;
        regIdxT prevDst;
        if (i == 0)
            return 1'b0;
        cur     = vecInstr[i];
        prevDst = vecDst[i-1];
        if (!vecWrite[i-1] || prevDst == '0)
            return 1'b0;
        if (cur[25:21] == prevDst)
            return 1'b1;
        return (cur[31:26] == `RTYPE) && (cur[20:16] == prevDst);   // rt is a source
    endfunction

    // Called on a falling edge, returns on the next one
    task automatic sendInstr(int i);
        expectT e;
        e.write = vecWrite[i];
        e.dst   = vecDst[i];
        e.data  = vecData[i];
        e.due   = cycleCnt + 2;
        e.idx   = i;
        expQ.push_back(e);
        instr      = vecInstr[i];
        instrValid = 1'b1;
        @(negedge clk);
        instrValid = 1'b0;
    endtask

    // ====================
    // Compare tasks
    task automatic checkWrite(input regIdxT expDst, input wordT expData, input int idx,
                              output bit ok);
        ok = 1'b1;
        if (wbValid !== 1'b1)
        begin
            $display("Vector %0d expected a write-back but wbValid stayed low", idx);
            ok = 1'b0;
        end
        else
        begin
            if (wbReg !== expDst)
            begin
                $display("MISMATCH at %0t: vector %0d wbReg is r%0d, expected r%0d",
                         $time, idx, wbReg, expDst);
                ok = 1'b0;
            end
            if (wbData !== expData)
            begin
                $display("MISMATCH at %0t: vector %0d wbData is %08h, expected %08h",
                         $time, idx, wbData, expData);
                ok = 1'b0;
            end
        end
    endtask

    task automatic checkNoWrite(input int idx, output bit ok);
        ok = (wbValid === 1'b0);
        if (!ok)
            $display("Vector %0d writes nothing but wbValid was raised for r%0d", idx, wbReg);
    endtask

    // ====================
    // Checker, samples between rising edges
    always @(negedge clk)
    begin
        if (rstN)
        begin
            if (expQ.size() > 0 && expQ[0].due == cycleCnt)
            begin
                popped = expQ.pop_front();
                if (popped.write)
                    checkWrite(popped.dst, popped.data, popped.idx, vecOk);
                else
                    checkNoWrite(popped.idx, vecOk);
                if (vecOk)
                begin
                    passCount++;
                    $display("Vector %0d (%08h) ok", popped.idx, vecInstr[popped.idx]);
                end
                else
                begin
                    failCount++;
                    $display("Vector %0d (%08h) failed", popped.idx, vecInstr[popped.idx]);
                end
            end
            else if (wbValid !== 1'b0)
            begin
                $display("Extra wbValid at %0t for r%0d with no instruction due", $time, wbReg);
                errors++;
            end
        end
    end

    // Watchdog
    initial
    begin
        wait (loaded);
        repeat (numVectors * 4 + 100 + ResetCycles) @(posedge clk);
        $display("Watchdog expired with %0d results outstanding", expQ.size());
        $display("STATUS: FAIL");
        $finish;
    end

    // ====================
    // Stimulus
    initial
    begin
        int unsigned gap;
        void'($urandom(45031));
        clk        = 1'b0;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        loadVectors();
        if (numVectors == 0)
        begin
            $display("No vectors were read");
            errors++;
        end
        loaded = 1'b1;

        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        repeat (3) @(negedge clk);   // Idle, wbValid must stay low

        for (int i = 0; i < numVectors; i++)
        begin
            if (i > 0 && !dependsOnPrevious(i))
            begin
                gap = $urandom_range(2, 0);
                repeat (gap) @(negedge clk);
            end
            sendInstr(i);
        end

        while (expQ.size() != 0)
            @(negedge clk);
        repeat (4) @(negedge clk);   // Catch stray write-backs

        $display("Vectors passed %0d, failed %0d, other errors %0d",
                 passCount, failCount, errors);
        if (failCount == 0 && errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* compile.f */
+incdir+hdl
hdl/isaPkg.sv
hdl/ctrlPkg.sv
hdl/instrDecoder.sv
hdl/regFile.sv
hdl/aluExecute.sv
hdl/writeBack.sv
hdl/execCore.sv
test/execCoreTb.sv

/* Makefile */
# Verilator build and run for the execute core testbench

SRCS := $(filter-out +%,$(shell cat compile.f)) hdl/mipsOp_macros.svh

obj_dir/VexecCoreTb: compile.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f \
		--top-module execCoreTb -o VexecCoreTb

.PHONY: run clean

run: obj_dir/VexecCoreTb
	@out="$$(./obj_dir/VexecCoreTb)"; echo "$$out"; echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf obj_dir

/* test/execVectors.txt */
// instr wr dst data: instruction word, write flag, destination register, data
// All fields hex; a write flag of 0 means no wbValid is expected
00000821 1 01 00000000  // ADDU r1, r0, r0
03dfe821 1 1d 00000000  // ADDU r29, r30, r31 unwritten regs
3c028000 1 02 80000000  // LUI r2, 0x8000
34421234 1 02 80001234  // ORI r2, r2, 0x1234 bypass
2403ffff 1 03 ffffffff  // ADDIU r3, r0, -1
20640005 1 04 00000004  // ADDI r4, r3, 5 wraps
3045ffff 1 05 00001234  // ANDI r5, r2, 0xffff zero ext
386600ff 1 06 ffffff00  // XORI r6, r3, 0x00ff
28670001 1 07 00000001  // SLTI r7, r3, 1
2c88ffff 1 08 00000001  // SLTIU r8, r4, -1
00854820 1 09 00001238  // ADD r9, r4, r5
00835022 1 0a 00000005  // SUB r10, r4, r3
00045822 1 0b fffffffc  // SUB r11, r0, r4
00466024 1 0c 80001200  // AND r12, r2, r6
00a76825 1 0d 00001235  // OR r13, r5, r7
00437026 1 0e 7fffedcb  // XOR r14, r2, r3
00a07827 1 0f ffffedcb  // NOR r15, r5, r0
0164802a 1 10 00000001  // SLT r16, r11, r4
0164882b 1 11 00000000  // SLTU r17, r11, r4
00059100 1 12 00012340  // SLL r18, r5, 4
00029a02 1 13 00800012  // SRL r19, r2, 8
0002a203 1 14 ff800012  // SRA r20, r2, 8
24150024 1 15 00000024  // ADDIU r21, r0, 36
02a5b004 1 16 00012340  // SLLV r22, r5, r21
02a6b806 1 17 0ffffff0  // SRLV r23, r6, r21
02a6c007 1 18 fffffff0  // SRAV r24, r6, r21
24190007 1 19 00000007  // ADDIU r25, r0, 7
0339c821 1 19 0000000e  // ADDU r25, r25, r25
0324d023 1 1a 0000000a  // SUBU r26, r25, r4
24001234 0 00 00000000  // ADDIU r0, r0, 0x1234
0000d821 1 1b 00000000  // ADDU r27, r0, r0
10220004 0 00 00000000  // BEQ r1, r2
8c030000 0 00 00000000  // LW r3, 0(r0)
00430018 0 00 00000000  // MULT r2, r3
0060e021 1 1c ffffffff  // ADDU r28, r3, r0
